/* filelist.f */
verilog/hispi_pkg.sv
verilog/video_pkg.sv
verilog/line_packer.sv
verilog/line_fifo.sv
verilog/lane_serializer.sv
verilog/hispi_tx.sv
sim/hispi_tx_asserts.sv
sim/tb_hispi_tx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the HiSPi transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_hispi_tx \
    -f filelist.f --Mdir obj_dir -o sim_tb || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

/* sim/hispi_tx_asserts.sv */
// Concurrent protocol checks for the HiSPi transmitter.
// Bound to every hispi_tx instance; watches the FIFO read handshake,
// lane readiness and the nibbles that each lane puts out.
`timescale 1ns/1ps
`default_nettype none

module hispi_tx_asserts
    import hispi_pkg::*;
    import video_pkg::*;
(
    input logic                            pclk,
    input logic                            rst,
    input logic                            rd_valid,
    input fifo_word_t                      rd_data,
    input logic [num_lanes-1:0]            lane_ready,
    input logic [num_lanes-1:0][nib_w-1:0] lanes
);

    logic                             accept;
    logic                             data_acc;
    logic                             sync_acc;
    logic [3:0]                       quiet;   // cycles left without ready after a sync
    logic [num_lanes-1:0][word_w-1:0] filt;    // data word as it should appear

    assign accept   = rd_valid && lane_ready[0];
    assign data_acc = accept && !rd_data.px.mark;
    assign sync_acc = accept && rd_data.mk.mark;

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            filt[i] = (rd_data.px.pix[i] inside {12'h000, 12'h001}) ? word_w'(1)
                                                                    : rd_data.px.pix[i];
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            quiet <= '0;
        end else if (sync_acc) begin
            quiet <= 4'd11;   // fff, 000, 000 then last beat of the code word
        end else if (quiet != '0) begin
            quiet <= quiet - 1'b1;
        end
    end

    a_ready_equal: assert property (@(posedge pclk) disable iff (rst)
        lane_ready == {num_lanes{lane_ready[0]}}) else $error("lane readies differ");

    a_word_held: assert property (@(posedge pclk) disable iff (rst)
        rd_valid && !lane_ready[0] |=> rd_valid && $stable(rd_data))
        else $error("fifo word dropped before it was taken");

    a_word_boundary: assert property (@(posedge pclk) disable iff (rst)
        lane_ready[0] |-> !$past(lane_ready[0]) && !$past(lane_ready[0], 2))
        else $error("ready raised inside a word");

    a_sync_quiet: assert property (@(posedge pclk) disable iff (rst)
        quiet != '0 |-> !lane_ready[0]) else $error("ready during a sync sequence");

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        a_sync_start: assert property (@(posedge pclk) disable iff (rst)
            $past(sync_acc) |-> lanes[i] == 4'hf) else $error("sync does not start with fff");

        a_pix_nib0: assert property (@(posedge pclk) disable iff (rst)
            $past(data_acc) |-> lanes[i] == $past(filt[i][3:0]))
            else $error("pixel nibble 0 mismatch on lane");

        a_pix_nib1: assert property (@(posedge pclk) disable iff (rst)
            $past(data_acc, 2) |-> lanes[i] == $past(filt[i][7:4], 2))
            else $error("pixel nibble 1 mismatch on lane");

        a_pix_nib2: assert property (@(posedge pclk) disable iff (rst)
            $past(data_acc, 3) |-> lanes[i] == $past(filt[i][11:8], 3))
            else $error("pixel nibble 2 mismatch on lane");
    end

endmodule

bind hispi_tx hispi_tx_asserts u_asserts (
    .pclk       (pclk),
    .rst        (rst),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .lane_ready (lane_ready),
    .lanes      (lanes_o)
);

`default_nettype wire

/* sim/tb_hispi_tx.sv */
// Testbench for the HiSPi transmitter.
// Drives frames of random pixels, deserializes all four lanes and
// compares every received word with what the sent pixels predict.
`timescale 1ns/1ps
`default_nettype none

module tb_hispi_tx;
    import hispi_pkg::*;
    import video_pkg::*;

    logic                            pclk;
    logic                            rst;
    logic [pix_w-1:0]                pxd;
    logic                            vact;
    logic                            hact;
    logic [num_lanes-1:0][nib_w-1:0] lanes;
    logic                            overflow;

    logic [31:0]       rng;
    int                errors;
    int                tests;
    int                fails;
    int                err_mark;
    int                idle_cyc;
    bit                seen_frame;
    logic [35:0]       hist [num_lanes];     // last 9 nibbles, newest on top
    logic [word_w-1:0] w1 [num_lanes];
    logic [word_w-1:0] w2 [num_lanes];
    logic [word_w-1:0] w3 [num_lanes];
    int                beat [num_lanes];
    bit                aligned [num_lanes];
    logic [word_w:0]   expq [num_lanes][$];  // bit 12 set for a sync code

    hispi_tx dut (
        .pclk       (pclk),
        .rst        (rst),
        .pxd_i      (pxd),
        .vact_i     (vact),
        .hact_i     (hact),
        .lanes_o    (lanes),
        .overflow_o (overflow)
    );

    always #50 pclk = ~pclk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic step();
        @(posedge pclk);
        #5;
    endtask

    task automatic compare_word(input int i, input logic [word_w:0] got);
        logic [word_w:0] e;
        if (expq[i].size() == 0) begin
            $display("lane %0d sent word %h with nothing left to receive", i, got);
            errors++;
        end else begin
            e = expq[i].pop_front();
            assert (got == e) else begin
                $display("[ERROR] lanes_o[%0d] word: got %h, expected %h", i, got, e);
                errors++;
            end
        end
    endtask

    // lane deserializers, sampled away from the driving edge
    always @(negedge pclk) begin
        logic [word_w-1:0] w;
        if (rst) begin
            idle_cyc = 0;
            for (int i = 0; i < num_lanes; i++) begin
                hist[i]    = '0;
                aligned[i] = 1'b0;
            end
        end else begin
            idle_cyc++;
            assert (!overflow) else begin
                $display("[ERROR] overflow_o: got %h, expected %h", overflow, 1'b0);
                errors++;
            end
            for (int i = 0; i < num_lanes; i++) begin
                hist[i] = {lanes[i], hist[i][35:4]};
                if (!seen_frame && idle_cyc >= 12) begin
                    assert (hist[i][11:0] inside {12'h800, 12'h080, 12'h008}) else begin
                        $display("[ERROR] lanes_o[%0d] idle: got %h, expected %h",
                                 i, hist[i][11:0], idle_word);
                        errors++;
                    end
                end
                if (!aligned[i]) begin
                    if (hist[i] == 36'h0_0000_0fff) begin   // fff, 000, 000 just ended
                        aligned[i] = 1'b1;
                        beat[i]    = 0;
                        w3[i]      = 12'hfff;
                        w2[i]      = '0;
                        w1[i]      = '0;
                    end
                end else begin
                    beat[i]++;
                    if (beat[i] == beats_per_word) begin
                        beat[i] = 0;
                        w       = hist[i][35:24];
                        if (w3[i] == 12'hfff && w2[i] == '0 && w1[i] == '0) begin
                            compare_word(i, {1'b1, w});
                        end else if (w == idle_word) begin
                            // no idle while data of a line is still due
                            assert (expq[i].size() == 0 || expq[i][0][word_w]) else begin
                                $display("idle word inside a line on lane %0d", i);
                                errors++;
                            end
                        end else if (w != 12'hfff && w != '0) begin
                            compare_word(i, {1'b0, w});
                        end
                        w3[i] = w2[i];
                        w2[i] = w1[i];
                        w1[i] = w;
                    end
                end
            end
        end
    end

    task automatic send_frame(input int lines, input int base_len);
        int               len;
        int               padded;
        logic [pix_w-1:0] p;
        logic [word_w-1:0] code;
        seen_frame = 1'b1;
        vact = 1'b1;
        repeat (3) step();
        for (int l = 0; l < lines; l++) begin
            len    = base_len + 3 * l;
            padded = ((len + 3) / 4) * 4;
            code   = word_w'(l == 0 ? sync_sof : sync_sol);
            if (l < embed_lines) begin
                code[embed_bit] = 1'b1;
            end
            for (int i = 0; i < num_lanes; i++) begin
                expq[i].push_back({1'b1, code});
            end
            for (int j = 0; j < len; j++) begin
                rng = xorshift(rng);
                p   = rng[pix_w-1:0];
                if (j % 7 == 3) p = '0;
                if (j % 11 == 5) p = 12'h001;
                if (p == 12'hfff || p == idle_word) p = p ^ 12'h001;  // keep words unambiguous
                hact = 1'b1;
                pxd  = p;
                expq[j % num_lanes].push_back(
                    {1'b0, (p inside {12'h000, 12'h001}) ? word_w'(1) : p});
                step();
            end
            for (int j = len; j < padded; j++) begin
                expq[j % num_lanes].push_back({1'b0, word_w'(1)});  // zero pad sent as 1
            end
            hact = 1'b0;
            pxd  = '0;
            repeat (len + 24) step();
        end
        vact = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            expq[i].push_back({1'b1, word_w'(sync_eof)});
        end
        repeat (6) step();
    endtask

    task automatic drain_lanes();
        int  n;
        bit  busy;
        n    = 0;
        busy = 1'b1;
        while (busy && n < 3000) begin
            busy = 1'b0;
            for (int i = 0; i < num_lanes; i++) begin
                if (expq[i].size() != 0) busy = 1'b1;
            end
            step();
            n++;
        end
        if (busy) begin
            $display("timeout while waiting for the lanes to send all words");
            errors++;
        end
        repeat (20) step();
    endtask

    task automatic report(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            fails++;
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        pclk       = 1'b0;
        rst        = 1'b1;
        pxd        = '0;
        vact       = 1'b0;
        hact       = 1'b0;
        rng        = 32'hec9b_8125;
        errors     = 0;
        tests      = 0;
        fails      = 0;
        err_mark   = 0;
        seen_frame = 1'b0;
        repeat (8) step();
        rst = 1'b0;

        repeat (30) step();
        report("idle after reset");

        send_frame(4, 13);
        repeat (6) step();   // short gap between frames
        send_frame(3, 6);
        drain_lanes();
        report("two frames back to back");

        send_frame(5, 9);
        drain_lanes();
        report("third frame");

        $display("%0d tests, %0d failed, %0d errors", tests, fails, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/hispi_pkg.sv */
// HiSPi packetized-SP protocol constants shared by the lane serializers,
// the transmitter top level and the protocol assertions.
// Import with a wildcard in the module header wherever sync codes,
// the idle word or the lane bit order are needed.
`default_nettype none

package hispi_pkg;

    // serial word on one lane
    localparam int word_w         = 12;
    localparam int nib_w          = 4;   // bits per lane per pclk
    localparam int beats_per_word = word_w / nib_w;

    // words in a sync sequence: fff, 000, 000, code
    localparam int sync_words = 4;

    // sent whenever no data word is pending
    localparam logic [word_w-1:0] idle_word = 12'h800;

    // sync codes, low bits of the last sync word
    localparam logic [3:0] sync_sof = 4'd3;
    localparam logic [3:0] sync_sol = 4'd1;
    localparam logic [3:0] sync_eof = 4'd7;

    // embedded-data flag position inside the code word
    localparam int embed_bit = 4;

    // 0 sends the least significant nibble first
    localparam bit msb_first = 1'b0;

endpackage

`default_nettype wire

/* verilog/hispi_tx.sv */
// HiSPi packetized-SP four lane transmitter.
// Parallel 12-bit pixels with frame and line valid go in,
// four 4-bit lane streams come out, all on pclk.
// overflow_o is sticky and reports a write lost in the line FIFO.
`timescale 1ns/1ps
`default_nettype none

module hispi_tx
    import hispi_pkg::*;
    import video_pkg::*;
(
    input  logic                            pclk,
    input  logic                            rst,
    input  logic [pix_w-1:0]                pxd_i,
    input  logic                            vact_i,
    input  logic                            hact_i,
    output logic [num_lanes-1:0][nib_w-1:0] lanes_o,
    output logic                            overflow_o
);

    logic                 wr_en;
    fifo_word_t           wr_data;
    logic                 line_done;
    logic                 rd_valid;
    fifo_word_t           rd_data;
    logic [num_lanes-1:0] lane_ready;   // all equal, lane 0 drives the FIFO
    logic [3:0]           sync_code;
    logic [word_w-1:0]    code_word;

    line_packer u_packer (
        .pclk        (pclk),
        .rst         (rst),
        .pxd_i       (pxd_i),
        .vact_i      (vact_i),
        .hact_i      (hact_i),
        .wr_en_o     (wr_en),
        .wr_data_o   (wr_data),
        .line_done_o (line_done)
    );

    line_fifo u_fifo (
        .pclk        (pclk),
        .rst         (rst),
        .wr_en_i     (wr_en),
        .wr_data_i   (wr_data),
        .line_done_i (line_done),
        .rd_valid_o  (rd_valid),
        .rd_data_o   (rd_data),
        .rd_ready_i  (lane_ready[0]),
        .overflow_o  (overflow_o)
    );

    // marker view to sync code word
    assign sync_code = (rd_data.mk.kind == kind_sof) ? sync_sof :
                       (rd_data.mk.kind == kind_sol) ? sync_sol : sync_eof;
    assign code_word = word_w'(sync_code) | (word_w'(rd_data.mk.embed) << embed_bit);

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        lane_serializer u_lane (
            .pclk    (pclk),
            .rst     (rst),
            .din_i   ({rd_data.mk.mark, rd_data.mk.mark ? code_word : rd_data.px.pix[i]}),
            .valid_i (rd_valid),
            .ready_o (lane_ready[i]),
            .lane_o  (lanes_o[i])
        );
    end

endmodule

`default_nettype wire

/* verilog/lane_serializer.sv */
// One HiSPi lane: sends a 12-bit word every three pclk cycles,
// four bits per cycle. A marker entry expands into the sync sequence
// fff, 000, 000, code; data words 0 and 1 are sent as 1; idle_word
// fills every slot with nothing pending. Ready is raised only on the
// last beat of a word.
`timescale 1ns/1ps
`default_nettype none

module lane_serializer
    import hispi_pkg::*;
    import video_pkg::*;
(
    input  logic             pclk,
    input  logic             rst,
    input  logic [pix_w:0]   din_i,     // marker flag, then pixel or code word
    input  logic             valid_i,
    output logic             ready_o,
    output logic [nib_w-1:0] lane_o
);

    localparam int bcnt_w = $clog2(beats_per_word);
    localparam int seq_w  = sync_words - 1;

    logic [bcnt_w-1:0] bcnt;        // beat inside the current word
    logic              last_beat;
    logic [seq_w-1:0]  seq;         // sync words still to send after fff
    logic [word_w-1:0] din_q;       // accepted word, keeps the sync code
    logic [word_w-1:0] sr;
    logic [word_w-1:0] data_filt;
    logic [word_w-1:0] next_word;
    logic              is_sync;
    logic              accept;

    assign last_beat = (bcnt == bcnt_w'(beats_per_word - 1));
    assign ready_o   = last_beat && (seq == '0);
    assign accept    = valid_i && ready_o;
    assign is_sync   = din_i[pix_w];

    // keep data away from the 000 sync words
    assign data_filt = (din_i[pix_w-1:1] == '0) ? word_w'(1) : din_i[pix_w-1:0];

    always_comb begin
        if (accept) begin
            next_word = is_sync ? '1 : data_filt;
        end else if (seq != '0) begin
            next_word = (seq[seq_w-1:1] != '0) ? '0 : din_q;  // code word goes last
        end else begin
            next_word = idle_word;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            bcnt <= '0;
            seq  <= '0;
            sr   <= idle_word;
        end else begin
            bcnt <= last_beat ? '0 : bcnt + 1'b1;
            if (last_beat) begin
                sr <= next_word;
                if (accept && is_sync) begin
                    seq <= '1;
                end else begin
                    seq <= seq >> 1;
                end
            end else if (msb_first) begin
                sr <= {sr[word_w-nib_w-1:0], nib_w'(0)};
            end else begin
                sr <= {nib_w'(0), sr[word_w-1:nib_w]};
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (accept) begin
            din_q <= din_i[pix_w-1:0];
        end
    end

    assign lane_o = msb_first ? sr[word_w-1 -: nib_w] : sr[nib_w-1:0];

endmodule

`default_nettype wire

/* verilog/line_fifo.sv */
// Line FIFO between the packer and the lane serializers.
// A line is released to the read side only after the entry closing it
// (next SOL or EOF) has been written, so lines go out without gaps.
// Writes into a full FIFO are dropped and flagged by overflow_o.
`timescale 1ns/1ps
`default_nettype none

module line_fifo
    import video_pkg::*;
(
    input  logic       pclk,
    input  logic       rst,
    input  logic       wr_en_i,
    input  fifo_word_t wr_data_i,
    input  logic       line_done_i,
    output logic       rd_valid_o,
    output fifo_word_t rd_data_o,
    input  logic       rd_ready_i,
    output logic       overflow_o
);

    localparam int depth = 1 << fifo_aw;

    fifo_word_t         mem [depth];
    logic [fifo_aw:0]   wa;             // extra msb tells full from empty
    logic [fifo_aw:0]   ra;
    logic [fifo_aw-1:0] lines_avail;    // complete lines stored
    logic               empty;
    logic               full;
    logic               head_is_line;   // SOF or SOL at the read side
    logic               wr_drop;
    logic               line_add;
    logic               line_sub;
    logic               rd_fire;

    assign empty = (wa == ra);
    assign full  = (wa[fifo_aw] != ra[fifo_aw]) && (wa[fifo_aw-1:0] == ra[fifo_aw-1:0]);

    assign rd_data_o    = mem[ra[fifo_aw-1:0]];
    assign head_is_line = rd_data_o.mk.mark && (rd_data_o.mk.kind != kind_eof);

    // hold back a line marker until its line is complete
    assign rd_valid_o = !empty && !(head_is_line && (lines_avail == '0));
    assign rd_fire    = rd_valid_o && rd_ready_i;

    assign wr_drop  = wr_en_i && full;
    assign line_add = line_done_i && !wr_drop;   // closing entry lost, line stays closed
    assign line_sub = rd_fire && head_is_line;

    always_ff @(posedge pclk) begin
        if (wr_en_i && !full) begin
            mem[wa[fifo_aw-1:0]] <= wr_data_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            wa          <= '0;
            ra          <= '0;
            lines_avail <= '0;
            overflow_o  <= 1'b0;
        end else begin
            if (wr_en_i && !full) begin
                wa <= wa + 1'b1;
            end

            if (rd_fire) begin
                ra <= ra + 1'b1;
            end

            if (line_add && !line_sub) begin
                lines_avail <= lines_avail + 1'b1;
            end else if (!line_add && line_sub) begin
                lines_avail <= lines_avail - 1'b1;
            end

            if (wr_drop) begin
                overflow_o <= 1'b1;   // sticky
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/line_packer.sv */
// Packs the parallel pixel stream into line FIFO entries.
// Writes an SOF or SOL marker when a line starts, a group of four pixels
// per lane set, and EOF when frame-valid falls. Short lines are padded
// with zero pixels up to a multiple of four.
`timescale 1ns/1ps
`default_nettype none

module line_packer
    import video_pkg::*;
(
    input  logic             pclk,
    input  logic             rst,
    input  logic [pix_w-1:0] pxd_i,
    input  logic             vact_i,
    input  logic             hact_i,
    output logic             wr_en_o,
    output fifo_word_t       wr_data_o,
    output logic             line_done_o
);

    localparam int cnt_w = $clog2(num_lanes);
    localparam int emb_w = $clog2(embed_lines + 1);

    logic [cnt_w-1:0]                pcntr;       // pixel position inside a group
    logic                            hact;        // hact stretched over padding
    logic                            vact_d;
    logic                            hact_d;
    logic                            next_sof;    // next line is the first of a frame
    logic [emb_w-1:0]                embed_left;
    logic [num_lanes-1:0][pix_w-1:0] group;
    logic [pix_w-1:0]                pix_in;
    logic                            we_data;
    logic                            we_line;
    logic                            we_eof;
    fifo_word_t                      entry;

    assign hact   = vact_i && (hact_i || (pcntr != '0));
    assign pix_in = hact_i ? pxd_i : '0;   // padding pixels read 0

    assign we_data = vact_d && hact_d && (pcntr == '0);  // fourth pixel just shifted in
    assign we_line = hact && !hact_d;
    assign we_eof  = vact_d && !vact_i;

    // entry written one cycle later
    always_comb begin
        entry = '0;
        if (we_data) begin
            entry.px.mark = 1'b0;
            entry.px.pix  = group;
        end else begin
            entry.mk.mark = 1'b1;
            if (we_eof) begin
                entry.mk.kind  = kind_eof;
                entry.mk.embed = 1'b0;
            end else begin
                entry.mk.kind  = next_sof ? kind_sof : kind_sol;
                entry.mk.embed = (embed_left != '0);
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            vact_d      <= 1'b0;
            hact_d      <= 1'b0;
            pcntr       <= '0;
            next_sof    <= 1'b1;
            embed_left  <= emb_w'(embed_lines);
            wr_en_o     <= 1'b0;
            line_done_o <= 1'b0;
        end else begin
            vact_d <= vact_i;
            hact_d <= hact;

            if (!vact_i) begin
                pcntr <= '0;
            end else if (hact) begin
                pcntr <= pcntr + 1'b1;
            end

            if (!vact_i) begin
                next_sof <= 1'b1;
            end else if (we_line) begin
                next_sof <= 1'b0;
            end

            // one embedded line done at each line end
            if (!vact_i) begin
                embed_left <= emb_w'(embed_lines);
            end else if (hact_d && !hact && (embed_left != '0)) begin
                embed_left <= embed_left - 1'b1;
            end

            wr_en_o     <= we_data || we_line || we_eof;
            line_done_o <= (we_line && !next_sof) || we_eof;  // closes the previous line
        end
    end

    always_ff @(posedge pclk) begin
        if (hact) begin
            group <= {pix_in, group[num_lanes-1:1]};  // first pixel ends in lane 0
        end
        wr_data_o <= entry;
    end

endmodule

`default_nettype wire

/* verilog/video_pkg.sv */
// Pixel-side constants and the line FIFO word format.
// A FIFO word is read either as four pixels (one per lane)
// or as a frame/line marker, selected by its top bit.
`default_nettype none

package video_pkg;

    localparam int pix_w       = 12;
    localparam int num_lanes   = 4;
    localparam int embed_lines = 2;   // lines flagged as embedded data per frame
    localparam int fifo_aw     = 10;

    // marker kinds
    localparam logic [1:0] kind_sof = 2'd0;
    localparam logic [1:0] kind_sol = 2'd1;
    localparam logic [1:0] kind_eof = 2'd2;

    // mark = 1 selects the marker view
    typedef union packed {
        struct packed {
            logic                            mark;
            logic [num_lanes-1:0][pix_w-1:0] pix;   // lane 0 in pix[0]
        } px;
        struct packed {
            logic        mark;
            logic [44:0] zero;
            logic        embed;
            logic [1:0]  kind;
        } mk;
    } fifo_word_t;

endpackage

`default_nettype wire
